// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and search the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f --top-module periph_tb \
	-o periph_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/periph_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Result: PASSED" && exit 0 || exit 1

// File: src/periph_addr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module periph_addr_decode (
	input  periph_pkg::bus_req_t  core_req_i,
	input  periph_pkg::bus_req_t  cs_req_i,
	output periph_pkg::port_cmd_t core_cmd_o,
	output periph_pkg::port_cmd_t cs_cmd_o
);

	import periph_pkg::*;

	// one lookup shared by both ports
	function automatic reg_sel_e addr_to_sel(input logic [periph_addr_w-1:0] addr);
		reg_sel_e sel;
		case (addr)
			addr_comm_reg0:     sel = sel_comm_reg0;
			addr_comm_control:  sel = sel_comm_control;
			addr_phase:         sel = sel_phase;
			addr_metric_switch: sel = sel_metric_switch;
			addr_stats:         sel = sel_stats;
			addr_reset_control: sel = sel_reset_control;
			addr_comm_cache0:   sel = sel_cache0;
			addr_comm_cache1:   sel = sel_cache1;
			addr_comm_cache2:   sel = sel_cache2;
			default:            sel = sel_none;
		endcase
		return sel;
	endfunction

	// strobes from req and rw, no access filtering here
	function automatic port_cmd_t req_to_cmd(input bus_req_t bus_req);
		port_cmd_t cmd;
		cmd.sel  = addr_to_sel(bus_req.addr);
		cmd.wr   = bus_req.req & bus_req.rw;
		cmd.rd   = bus_req.req & ~bus_req.rw;
		cmd.data = bus_req.wdata;
		return cmd;
	endfunction

	always_comb begin
		core_cmd_o = req_to_cmd(core_req_i);
	end

	always_comb begin
		// sel stays valid without req, read return needs it while held
		cs_cmd_o = req_to_cmd(cs_req_i);
	end

endmodule

`default_nettype wire

// File: src/periph_pkg.sv
`default_nettype none

package periph_pkg;

	// bus widths
	localparam int periph_addr_w = 8;
	localparam int periph_data_w = 32;

	// byte address map shared by both buses
	localparam logic [periph_addr_w-1:0] addr_comm_reg0      = 8'h00;
	localparam logic [periph_addr_w-1:0] addr_comm_control   = 8'h04;
	localparam logic [periph_addr_w-1:0] addr_phase          = 8'h08;
	localparam logic [periph_addr_w-1:0] addr_metric_switch  = 8'h0C;
	localparam logic [periph_addr_w-1:0] addr_stats          = 8'h10;
	localparam logic [periph_addr_w-1:0] addr_reset_control  = 8'h14;
	localparam logic [periph_addr_w-1:0] addr_comm_cache0    = 8'h18;
	localparam logic [periph_addr_w-1:0] addr_comm_cache1    = 8'h1C;
	localparam logic [periph_addr_w-1:0] addr_comm_cache2    = 8'h20;

	// cycle counter words on the stats bus
	localparam int num_cycle_counts = 6;

	// returned while the subsystem sits in reset
	localparam logic [periph_data_w-1:0] read_poison = 32'hDEADBEAF;

	// raw request as it arrives on either bus
	typedef struct packed {
		logic                     req;
		logic                     rw;
		logic [periph_addr_w-1:0] addr;
		logic [periph_data_w-1:0] wdata;
	} bus_req_t;

	// register targeted by an address
	typedef enum logic [3:0] {
		sel_none,
		sel_comm_reg0,
		sel_comm_control,
		sel_phase,
		sel_metric_switch,
		sel_stats,
		sel_reset_control,
		sel_cache0,
		sel_cache1,
		sel_cache2
	} reg_sel_e;

	// decoded command for one port
	typedef struct packed {
		reg_sel_e                 sel;
		logic                     wr;
		logic                     rd;
		logic [periph_data_w-1:0] data;
	} port_cmd_t;

	// readable state of the register bank
	typedef struct packed {
		logic [periph_data_w-1:0] comm_reg0;
		logic [periph_data_w-1:0] comm_reg1;
		logic [1:0]               reset_reg;
	} reg_view_t;

endpackage

`default_nettype wire

// File: src/periph_read_return.sv
`timescale 1ns/1ns
`default_nettype none

module periph_read_return (
	input  wire                                  clock_i,
	input  periph_pkg::port_cmd_t                core_cmd_i,
	input  periph_pkg::port_cmd_t                cs_cmd_i,
	input  periph_pkg::reg_view_t                view_i,
	input  wire                                  subsys_hold_i,
	input  wire  [periph_pkg::periph_data_w-1:0] comm_cache0_i,
	input  wire  [periph_pkg::periph_data_w-1:0] comm_cache1_i,
	input  wire  [periph_pkg::periph_data_w-1:0] comm_cache_l2_i,
	output logic [periph_pkg::periph_data_w-1:0] core_rdata_o,
	output logic [periph_pkg::periph_data_w-1:0] cs_rdata_o
);

	import periph_pkg::*;

	logic [periph_data_w-1:0] reset_word;

	// upper bits read as ones
	assign reset_word = {{(periph_data_w-2){1'b1}}, view_i.reset_reg};

	// core port only sees the mailbox
	always_ff @(posedge clock_i) begin
		if (subsys_hold_i) begin
			core_rdata_o <= read_poison;
		end else if (core_cmd_i.rd && core_cmd_i.sel == sel_comm_reg0) begin
			core_rdata_o <= view_i.comm_reg0;
		end
	end

	always_ff @(posedge clock_i) begin
		if (subsys_hold_i) begin
			// refreshed every cycle so the reset register stays visible
			if (cs_cmd_i.sel == sel_reset_control) begin
				cs_rdata_o <= reset_word;
			end else begin
				cs_rdata_o <= read_poison;
			end
		end else if (cs_cmd_i.rd) begin
			case (cs_cmd_i.sel)
				sel_comm_reg0:     cs_rdata_o <= view_i.comm_reg0;
				sel_stats:         cs_rdata_o <= view_i.comm_reg1;
				sel_reset_control: cs_rdata_o <= reset_word;
				// cache status words
				sel_cache0:        cs_rdata_o <= comm_cache0_i;
				sel_cache1:        cs_rdata_o <= comm_cache1_i;
				sel_cache2:        cs_rdata_o <= comm_cache_l2_i;
				default:           cs_rdata_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/periph_reg_bank.sv
`timescale 1ns/1ns
`default_nettype none

module periph_reg_bank (
	input  wire                              clock_i,
	input  wire                              cpu_resetn_i,
	input  periph_pkg::port_cmd_t            core_cmd_i,
	input  periph_pkg::port_cmd_t            cs_cmd_i,
	input  wire [periph_pkg::num_cycle_counts-1:0][periph_pkg::periph_data_w-1:0]
	                                         cycle_counts_i,
	output periph_pkg::reg_view_t            view_o,
	output logic                             subsys_hold_o,
	output logic [1:0]                       metric_sel_o,
	output logic [15:0]                      sample_rate_o,
	output logic [periph_pkg::periph_data_w-1:0] phase_o,
	output logic [periph_pkg::periph_data_w-1:0] comm_o,
	output logic                             reset_system_o
);

	import periph_pkg::*;

	logic [periph_data_w-1:0] comm_reg0_q;
	logic [periph_data_w-1:0] comm_reg1_q;
	logic [7:0]               comm_core_q;
	logic [23:0]              comm_cs_q;
	logic [periph_data_w-1:0] phase_q;
	logic [1:0]               metric_sel_q;
	logic [15:0]              sample_rate_q;
	logic [1:0]               reset_reg_q;
	logic [periph_data_w-1:0] stats_word;
	logic [2:0]               stats_idx;

	// 11 minus the highest set bit, 11 for fields 0 and 1
	function automatic logic [3:0] shift_code(input logic [11:0] field);
		logic [3:0] code;
		code = 4'd11;
		for (int i = 0; i < 12; i++) begin
			if (field[i]) begin
				code = 4'(11 - i);
			end
		end
		return code;
	endfunction

	// counter word picked by a stats write
	assign stats_idx = cs_cmd_i.data[2:0];

	always_comb begin
		stats_word = '0;
		if (int'(stats_idx) < num_cycle_counts) begin
			stats_word = cycle_counts_i[stats_idx];
		end
	end

	always_ff @(posedge clock_i) begin
		if (!cpu_resetn_i || subsys_hold_o) begin
			comm_reg0_q   <= '0;
			comm_reg1_q   <= '0;
			comm_core_q   <= '0;
			comm_cs_q     <= '0;
			phase_q       <= '0;
			metric_sel_q  <= '0;
			sample_rate_q <= '0;
		end else begin
			// sampler clear / table dump and phase interrupt pulse for one cycle
			comm_cs_q[23:22] <= 2'b00;
			phase_q[31]      <= 1'b0;

			// core may write mailbox, its comm field and phase
			if (core_cmd_i.wr) begin
				case (core_cmd_i.sel)
					sel_comm_reg0:    comm_reg0_q <= core_cmd_i.data;
					sel_comm_control: comm_core_q <= core_cmd_i.data[7:0];
					sel_phase:        phase_q <= {1'b1, core_cmd_i.data[30:0]};
					default: ;
				endcase
			end

			// control system side
			if (cs_cmd_i.wr) begin
				case (cs_cmd_i.sel)
					sel_comm_control: comm_cs_q <= cs_cmd_i.data[23:0];
					sel_metric_switch: begin
						metric_sel_q <= cs_cmd_i.data[1:0];
						if (cs_cmd_i.data[1:0] == 2'd1) begin
							// sampler seed plus shift
							sample_rate_q <= {cs_cmd_i.data[25:14],
							                  shift_code(cs_cmd_i.data[13:2])};
						end else begin
							sample_rate_q <= cs_cmd_i.data[17:2];
						end
					end
					sel_stats: comm_reg1_q <= stats_word;
					default: ;
				endcase
			end
		end
	end

	// software reset register, only the cpu reset clears it
	always_ff @(posedge clock_i) begin
		if (!cpu_resetn_i) begin
			reset_reg_q <= 2'b00;
		end else if (cs_cmd_i.wr && cs_cmd_i.sel == sel_reset_control) begin
			reset_reg_q <= cs_cmd_i.data[1:0];
		end
	end

	assign subsys_hold_o  = ~reset_reg_q[1];
	assign reset_system_o = reset_reg_q[0];

	assign metric_sel_o  = metric_sel_q;
	assign sample_rate_o = sample_rate_q;
	assign phase_o       = phase_q;
	assign comm_o        = {comm_core_q, comm_cs_q};

	assign view_o = '{
		comm_reg0: comm_reg0_q,
		comm_reg1: comm_reg1_q,
		reset_reg: reset_reg_q
	};

endmodule

`default_nettype wire

// File: src/periph_system_top.sv
`timescale 1ns/1ns
`default_nettype none

module periph_system_top (
	input  wire                                  clock_i,
	input  wire                                  cpu_resetn_i,

	// core bus
	input  wire                                  core_req_i,
	input  wire                                  core_rw_i,
	input  wire  [periph_pkg::periph_addr_w-1:0] core_addr_i,
	input  wire  [periph_pkg::periph_data_w-1:0] core_wdata_i,
	output logic [periph_pkg::periph_data_w-1:0] core_rdata_o,

	// control system bus
	input  wire                                  cs_req_i,
	input  wire                                  cs_rw_i,
	input  wire  [periph_pkg::periph_addr_w-1:0] cs_addr_i,
	input  wire  [periph_pkg::periph_data_w-1:0] cs_wdata_i,
	output logic [periph_pkg::periph_data_w-1:0] cs_rdata_o,

	// counters and cache status
	input  wire  [periph_pkg::num_cycle_counts-1:0][periph_pkg::periph_data_w-1:0]
	                                             cycle_counts_i,
	input  wire  [periph_pkg::periph_data_w-1:0] comm_cache0_i,
	input  wire  [periph_pkg::periph_data_w-1:0] comm_cache1_i,
	input  wire  [periph_pkg::periph_data_w-1:0] comm_cache_l2_i,

	// control outputs
	output logic [1:0]                           metric_sel_o,
	output logic [15:0]                          sample_rate_o,
	output logic [periph_pkg::periph_data_w-1:0] phase_o,
	output logic [periph_pkg::periph_data_w-1:0] comm_o,
	output logic                                 reset_system_o
);

	import periph_pkg::*;

	bus_req_t  core_req;
	bus_req_t  cs_req;
	port_cmd_t core_cmd;
	port_cmd_t cs_cmd;
	reg_view_t view;
	logic      subsys_hold;

	assign core_req = '{req: core_req_i, rw: core_rw_i, addr: core_addr_i, wdata: core_wdata_i};
	assign cs_req   = '{req: cs_req_i, rw: cs_rw_i, addr: cs_addr_i, wdata: cs_wdata_i};

	periph_addr_decode decode0 (
		.core_req_i (core_req),
		.cs_req_i   (cs_req),
		.core_cmd_o (core_cmd),
		.cs_cmd_o   (cs_cmd)
	);

	periph_reg_bank bank0 (
		.clock_i        (clock_i),
		.cpu_resetn_i   (cpu_resetn_i),
		.core_cmd_i     (core_cmd),
		.cs_cmd_i       (cs_cmd),
		.cycle_counts_i (cycle_counts_i),
		.view_o         (view),
		.subsys_hold_o  (subsys_hold),
		.metric_sel_o   (metric_sel_o),
		.sample_rate_o  (sample_rate_o),
		.phase_o        (phase_o),
		.comm_o         (comm_o),
		.reset_system_o (reset_system_o)
	);

	periph_read_return read0 (
		.clock_i         (clock_i),
		.core_cmd_i      (core_cmd),
		.cs_cmd_i        (cs_cmd),
		.view_i          (view),
		.subsys_hold_i   (subsys_hold),
		.comm_cache0_i   (comm_cache0_i),
		.comm_cache1_i   (comm_cache1_i),
		.comm_cache_l2_i (comm_cache_l2_i),
		.core_rdata_o    (core_rdata_o),
		.cs_rdata_o      (cs_rdata_o)
	);

endmodule

`default_nettype wire

// File: tb.f
src/periph_pkg.sv
src/periph_addr_decode.sv
src/periph_reg_bank.sv
src/periph_read_return.sv
src/periph_system_top.sv
verif/tb_clock_gen.sv
verif/periph_chk.sv
verif/periph_tb.sv

// File: verif/periph_chk.sv
`timescale 1ns/1ns
`default_nettype none

module periph_chk (
	input wire                                 clock_i,
	input wire                                 cpu_resetn_i,
	input wire                                 subsys_hold_i,
	input wire                                 core_req_i,
	input wire                                 core_rw_i,
	input wire [periph_pkg::periph_data_w-1:0] core_rdata_i,
	input wire                                 cs_req_i,
	input wire                                 cs_rw_i,
	input wire [periph_pkg::periph_addr_w-1:0] cs_addr_i,
	input wire [periph_pkg::periph_data_w-1:0] cs_wdata_i,
	input wire [periph_pkg::periph_data_w-1:0] comm_i,
	input wire [periph_pkg::periph_data_w-1:0] phase_i,
	input wire                                 reset_system_i
);

	import periph_pkg::*;

	int unsigned fail_count = 0;

	// sampler clear and table dump pulses
	comm_23_pulse: assert property (@(posedge clock_i) disable iff (!cpu_resetn_i)
		$rose(comm_i[23]) |=> !comm_i[23])
		else begin
			$error("comm bit 23 stayed high for more than one cycle");
			fail_count++;
		end

	comm_22_pulse: assert property (@(posedge clock_i) disable iff (!cpu_resetn_i)
		$rose(comm_i[22]) |=> !comm_i[22])
		else begin
			$error("comm bit 22 stayed high for more than one cycle");
			fail_count++;
		end

	// phase interrupt
	phase_31_pulse: assert property (@(posedge clock_i) disable iff (!cpu_resetn_i)
		$rose(phase_i[31]) |=> !phase_i[31])
		else begin
			$error("phase bit 31 stayed high for more than one cycle");
			fail_count++;
		end

	reset_low_in_cpu_reset: assert property (@(posedge clock_i)
		!cpu_resetn_i |=> !reset_system_i)
		else begin
			$error("reset_system high during cpu reset");
			fail_count++;
		end

	poison_while_held: assert property (@(posedge clock_i) disable iff (!cpu_resetn_i)
		(core_req_i && !core_rw_i && subsys_hold_i) |=> core_rdata_i == read_poison)
		else begin
			$error("core read while held did not return the poison word");
			fail_count++;
		end

	// bit 0 of the reset register drives the system reset
	reset_follows_write: assert property (@(posedge clock_i) disable iff (!cpu_resetn_i)
		(cs_req_i && cs_rw_i && cs_addr_i == addr_reset_control)
		|=> reset_system_i == $past(cs_wdata_i[0]))
		else begin
			$error("reset_system does not match the written reset control bit");
			fail_count++;
		end

endmodule

bind periph_system_top periph_chk chk0 (
	.clock_i        (clock_i),
	.cpu_resetn_i   (cpu_resetn_i),
	.subsys_hold_i  (subsys_hold),
	.core_req_i     (core_req_i),
	.core_rw_i      (core_rw_i),
	.core_rdata_i   (core_rdata_o),
	.cs_req_i       (cs_req_i),
	.cs_rw_i        (cs_rw_i),
	.cs_addr_i      (cs_addr_i),
	.cs_wdata_i     (cs_wdata_i),
	.comm_i         (comm_o),
	.phase_i        (phase_o),
	.reset_system_i (reset_system_o)
);

`default_nettype wire

// File: verif/periph_tb.sv
`timescale 1ns/1ns
`default_nettype none

module periph_tb;

	import periph_pkg::*;

	logic                              clock;
	logic                              cpu_resetn;
	bus_req_t                          core_bus;
	bus_req_t                          cs_bus;
	logic [31:0]                       core_rdata;
	logic [31:0]                       cs_rdata;
	logic [num_cycle_counts-1:0][31:0] counts;
	logic [2:0][31:0]                  caches;
	logic [1:0]                        metric_sel;
	logic [15:0]                       sample_rate;
	logic [31:0]                       phase;
	logic [31:0]                       comm;
	logic                              reset_system;
	logic [31:0]                       rng_state;
	logic [31:0]                       data;
	logic [31:0]                       cs_word;
	logic [31:0]                       word;
	logic [11:0]                       field;
	logic [3:0]                        code;
	logic [2:0]                        idx;
	string                             test_name;
	int                                errors;
	int                                errors_at_start;
	int                                tests_run;
	int                                tests_failed;

	tb_clock_gen clk_gen0 (
		.clock_o  (clock),
		.resetn_o (cpu_resetn)
	);

	periph_system_top dut0 (
		.clock_i         (clock),
		.cpu_resetn_i    (cpu_resetn),
		.core_req_i      (core_bus.req),
		.core_rw_i       (core_bus.rw),
		.core_addr_i     (core_bus.addr),
		.core_wdata_i    (core_bus.wdata),
		.core_rdata_o    (core_rdata),
		.cs_req_i        (cs_bus.req),
		.cs_rw_i         (cs_bus.rw),
		.cs_addr_i       (cs_bus.addr),
		.cs_wdata_i      (cs_bus.wdata),
		.cs_rdata_o      (cs_rdata),
		.cycle_counts_i  (counts),
		.comm_cache0_i   (caches[0]),
		.comm_cache1_i   (caches[1]),
		.comm_cache_l2_i (caches[2]),
		.metric_sel_o    (metric_sel),
		.sample_rate_o   (sample_rate),
		.phase_o         (phase),
		.comm_o          (comm),
		.reset_system_o  (reset_system)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
			tests_failed++;
		end
	endtask

	// drive one request for a single cycle and return the read data
	task automatic access(input logic on_cs, input logic rw, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		if (on_cs) begin
			cs_bus = '{req: 1'b1, rw: rw, addr: addr, wdata: wdata};
		end else begin
			core_bus = '{req: 1'b1, rw: rw, addr: addr, wdata: wdata};
		end
		next_cycle();
		cs_bus.req = 1'b0;
		core_bus.req = 1'b0;
		rdata = on_cs ? cs_rdata : core_rdata;
	endtask

	// reset level seen at each rising edge
	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (cpu_resetn !== 1'b1 && cycles < 40) begin
			@(posedge clock);
			cycles++;
		end
		#1;
		if (cpu_resetn !== 1'b1) begin
			$display("timeout: cpu reset was never released");
			errors++;
		end
	endtask

	// poll the reset word until bit 1 reads back set
	task automatic wait_hold_release();
		logic [31:0] rd;
		int          cycles;
		cycles = 0;
		rd = '0;
		while (rd != 32'hFFFF_FFFE && cycles < 20) begin
			access(1'b1, 1'b0, addr_reset_control, 32'h0, rd);
			cycles++;
		end
		if (rd != 32'hFFFF_FFFE) begin
			$display("timeout: subsystem hold did not release after writing 2");
			errors++;
		end
	endtask

	initial begin
		rng_state = 32'h5395_4dc5;
		core_bus = '0;
		cs_bus = '0;
		counts = '0;
		errors = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (num_cycle_counts) counts = {counts[num_cycle_counts-2:0], next_random()};
		caches = {next_random(), next_random(), next_random()};
		wait_reset_release();

		start_test("reset_hold");
		check_value("metric_sel", 32'h0, 32'(metric_sel));
		check_value("sample_rate", 32'h0, 32'(sample_rate));
		check_value("phase", 32'h0, phase);
		check_value("comm", 32'h0, comm);
		check_value("reset_system", 32'h0, 32'(reset_system));
		access(1'b0, 1'b1, addr_comm_reg0, next_random(), word);
		access(1'b0, 1'b0, addr_comm_reg0, 32'h0, word);
		check_value("core read held", read_poison, word);
		access(1'b1, 1'b0, addr_comm_reg0, 32'h0, word);
		check_value("cs read held", read_poison, word);
		access(1'b1, 1'b0, addr_reset_control, 32'h0, word);
		check_value("reset word held", 32'hFFFF_FFFC, word);
		access(1'b1, 1'b1, addr_reset_control, 32'h2, word);
		wait_hold_release();
		check_value("reset_system after 2", 32'h0, 32'(reset_system));
		access(1'b0, 1'b0, addr_comm_reg0, 32'h0, word);
		check_value("mailbox after release", 32'h0, word);
		access(1'b1, 1'b1, addr_reset_control, 32'h3, word);
		check_value("reset_system after 3", 32'h1, 32'(reset_system));
		access(1'b1, 1'b1, addr_reset_control, 32'h2, word);
		finish_test();

		start_test("mailbox");
		repeat (6) begin
			data = next_random();
			access(1'b0, 1'b1, addr_comm_reg0, data, word);
			access(1'b0, 1'b0, addr_comm_reg0, 32'h0, word);
			check_value("core readback", data, word);
			access(1'b1, 1'b0, addr_comm_reg0, 32'h0, word);
			check_value("cs readback", data, word);
		end
		access(1'b1, 1'b1, addr_comm_reg0, ~data, word);
		access(1'b1, 1'b0, addr_comm_reg0, 32'h0, word);
		check_value("cs write ignored", data, word);
		finish_test();

		start_test("comm_phase");
		data = next_random();
		access(1'b0, 1'b1, addr_comm_control, data, word);
		check_value("core field", 32'(data[7:0]), 32'(comm[31:24]));
		cs_word = next_random() | 32'h00C0_0000;
		access(1'b1, 1'b1, addr_comm_control, cs_word, word);
		check_value("comm with pulses", {data[7:0], cs_word[23:0]}, comm);
		next_cycle();
		check_value("comm after pulses", {data[7:0], 2'b00, cs_word[21:0]}, comm);
		data = next_random();
		access(1'b0, 1'b1, addr_phase, data, word);
		check_value("phase with pulse", {1'b1, data[30:0]}, phase);
		next_cycle();
		check_value("phase after pulse", {1'b0, data[30:0]}, phase);
		finish_test();

		start_test("metric_switch");
		for (int s = 0; s < 4; s++) begin
			if (s != 1) begin
				repeat (3) begin
					data = next_random();
					data[1:0] = 2'(s);
					access(1'b1, 1'b1, addr_metric_switch, data, word);
					check_value("selector", 32'(s), 32'(metric_sel));
					check_value("plain rate", 32'(data[17:2]), 32'(sample_rate));
				end
			end
		end
		// position -1 stands for an all-zero field
		for (int bit_pos = -1; bit_pos < 12; bit_pos++) begin
			data = next_random();
			data[1:0] = 2'd1;
			if (bit_pos < 0) begin
				data[13:2] = 12'h0;
				code = 4'd11;
			end else begin
				field = 12'(1) << bit_pos;
				data[13:2] = field | (data[13:2] & (field - 12'd1));
				code = 4'(11 - bit_pos);
			end
			access(1'b1, 1'b1, addr_metric_switch, data, word);
			check_value("seeded rate", 32'({data[25:14], code}), 32'(sample_rate));
		end
		finish_test();

		start_test("stats_status");
		for (int i = 0; i < 8; i++) begin
			idx = 3'(i);
			data = next_random();
			data[2:0] = idx;
			access(1'b1, 1'b1, addr_stats, data, word);
			access(1'b1, 1'b0, addr_stats, 32'h0, word);
			if (i < num_cycle_counts) begin
				check_value("counter word", counts[idx], word);
			end else begin
				check_value("counter out of range", 32'h0, word);
			end
		end
		access(1'b1, 1'b0, addr_comm_cache0, 32'h0, word);
		check_value("cache0", caches[0], word);
		access(1'b1, 1'b0, addr_comm_cache1, 32'h0, word);
		check_value("cache1", caches[1], word);
		access(1'b1, 1'b0, addr_comm_cache2, 32'h0, word);
		check_value("cache l2", caches[2], word);
		access(1'b1, 1'b0, 8'h40, 32'h0, word);
		check_value("unmapped", 32'h0, word);
		finish_test();

		$display("tests run: %0d, tests failed: %0d, check errors: %0d, assertion errors: %0d",
			tests_run, tests_failed, errors, dut0.chk0.fail_count);
		if (errors == 0 && dut0.chk0.fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clock_o,
	output logic resetn_o
);

	// 10 ns period
	initial begin
		clock_o = 1'b0;
		forever #5 clock_o = ~clock_o;
	end

	// reset held for 10 rising edges, released just after the last one
	initial begin
		resetn_o = 1'b0;
		repeat (10) @(posedge clock_o);
		#1;
		resetn_o = 1'b1;
	end

endmodule

`default_nettype wire
